/* hw/mix_pkg.sv */
`default_nettype none

package mix_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    // channel count, the sum tree is built around five
    localparam int NCH = 5;

    // raw adc word, offset binary
    typedef logic        [11:0] adc_word_t;
    // two's complement input sample
    typedef logic signed [11:0] in_sample_t;
    // one channel sample
    typedef logic signed [15:0] sample_t;
    // unsigned gain, 30 fractional bits by default
    typedef logic        [31:0] gain_t;
    // adder tree result, 16 bits plus three growth bits
    typedef logic signed [18:0] sum_t;
    // dac value, signed before formatting, offset binary after
    typedef logic        [13:0] dac_word_t;
    // final right shift amount
    typedef logic        [2:0]  shift_t;

    // ----------------------------------------
    // select codes
    // ----------------------------------------
    // captured input source, code 1 was the nco
    typedef enum logic [1:0] {
        IN_ADC      = 2'd0,
        IN_NONE     = 2'd1,
        IN_FEEDBACK = 2'd2,
        IN_RAMP     = 2'd3
    } input_sel_t;

    // channel source, codes 2 and 3 give zero
    typedef enum logic [1:0] {
        SRC_GAIN = 2'd0,
        SRC_CPU  = 2'd1,
        SRC_NONE = 2'd2
    } src_sel_t;

    // dac1 source
    typedef enum logic [1:0] {
        D1_CH0    = 2'd0,
        D1_CH4    = 2'd1,
        D1_NONE   = 2'd2,
        D1_SYSTEM = 2'd3
    } dac1_sel_t;

    // dac2 source
    typedef enum logic [1:0] {
        D2_CH1  = 2'd0,
        D2_CH2  = 2'd1,
        D2_CH3  = 2'd2,
        D2_SRC0 = 2'd3
    } dac2_sel_t;

    // ----------------------------------------
    // buses
    // ----------------------------------------
    // static configuration, 11 bits
    typedef struct packed {
        input_sel_t input_sel;
        src_sel_t   src_sel;
        dac1_sel_t  dac1_sel;
        dac2_sel_t  dac2_sel;
        shift_t     final_shift;
    } mix_cfg_t;

    typedef sample_t [NCH-1:0] ch_samples_t;
    typedef gain_t   [NCH-1:0] ch_gains_t;

endpackage

`default_nettype wire

/* hw/adc_input_select.sv */
`default_nettype none

module adc_input_select
    import mix_pkg::*;
(
    input  wire        sys_clk,
    input  wire        rst,
    input  adc_word_t  i_adc_data,
    input  wire [11:0] i_ramp_step,
    input  dac_word_t  i_feedback,
    input  input_sel_t i_input_sel,
    output in_sample_t o_cap_selected
);

    // ----------------------------------------
    // adc conversion
    // ----------------------------------------
    // offset binary to two's complement, flip the msb
    in_sample_t adc_q;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            adc_q <= '0;
        end else begin
            adc_q <= {~i_adc_data[11], i_adc_data[10:0]};
        end
    end

    // ----------------------------------------
    // test ramp
    // ----------------------------------------
    // 16-bit accumulator, top 12 bits form the saw
    logic [15:0] ramp_q;
    in_sample_t  ramp_saw;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            ramp_q <= '0;
        end else begin
            ramp_q <= ramp_q + {4'd0, i_ramp_step};
        end
    end

    // center around zero, -2048 .. +2047
    assign ramp_saw = in_sample_t'(ramp_q[15:4] - 12'd2048);

    // ----------------------------------------
    // capture select
    // ----------------------------------------
    in_sample_t cap_next;

    always_comb begin
        case (i_input_sel)
            IN_ADC:      cap_next = adc_q;
            IN_FEEDBACK: cap_next = in_sample_t'(i_feedback[13:2]);
            IN_RAMP:     cap_next = ramp_saw;
            // nco input is gone
            default:     cap_next = '0;
        endcase
    end

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            o_cap_selected <= '0;
        end else begin
            o_cap_selected <= cap_next;
        end
    end

endmodule

`default_nettype wire

/* hw/channel_source.sv */
`default_nettype none

module channel_source
    import mix_pkg::*;
#(
    parameter int GAIN_FRAC = 30
) (
    input  wire      sys_clk,
    input  wire      rst,
    input  sample_t  i_rx_sample,
    input  gain_t    i_gain,
    input  sample_t  i_cpu_sample,
    input  src_sel_t i_src_sel,
    output sample_t  o_source
);

    // ----------------------------------------
    // gain multiply
    // ----------------------------------------
    // gain is unsigned, extend with a zero sign bit
    logic signed [32:0] gain_s;
    logic signed [48:0] product;
    logic signed [48:0] product_shf;
    sample_t            gained;

    assign gain_s      = $signed({1'b0, i_gain});
    assign product     = i_rx_sample * gain_s;
    // drop the fractional bits, keep sign
    assign product_shf = product >>> GAIN_FRAC;
    // low 16 bits only, wraps on overflow
    assign gained      = product_shf[15:0];

    // ----------------------------------------
    // source select
    // ----------------------------------------
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            o_source <= '0;
        end else begin
            case (i_src_sel)
                SRC_GAIN: o_source <= gained;
                SRC_CPU:  o_source <= i_cpu_sample;
                // cpu nco codes, now zero
                default:  o_source <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/sum_tree.sv */
`default_nettype none

module sum_tree
    import mix_pkg::*;
(
    input  wire         sys_clk,
    input  wire         rst,
    input  ch_samples_t i_sources,
    output sum_t        o_sum
);

    // ----------------------------------------
    // stage 1, pairs at 17 bits
    // ----------------------------------------
    logic signed [16:0] sum01_q;
    logic signed [16:0] sum23_q;
    // channel 4 waits for the pairs
    logic signed [16:0] ch4_d1_q;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            sum01_q  <= '0;
            sum23_q  <= '0;
            ch4_d1_q <= '0;
        end else begin
            sum01_q  <= i_sources[0] + i_sources[1];
            sum23_q  <= i_sources[2] + i_sources[3];
            ch4_d1_q <= i_sources[4];
        end
    end

    // ----------------------------------------
    // stage 2, quad at 18 bits
    // ----------------------------------------
    logic signed [17:0] sum0123_q;
    logic signed [17:0] ch4_d2_q;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            sum0123_q <= '0;
            ch4_d2_q  <= '0;
        end else begin
            sum0123_q <= sum01_q + sum23_q;
            ch4_d2_q  <= ch4_d1_q;
        end
    end

    // ----------------------------------------
    // stage 3, final at 19 bits
    // ----------------------------------------
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            o_sum <= '0;
        end else begin
            o_sum <= sum0123_q + ch4_d2_q;
        end
    end

endmodule

`default_nettype wire

/* hw/output_scaler.sv */
`default_nettype none

module output_scaler
    import mix_pkg::*;
(
    input  sum_t      i_sum,
    input  shift_t    i_final_shift,
    output dac_word_t o_system
);

    // ----------------------------------------
    // round and shift
    // ----------------------------------------
    // half an lsb of the chosen shift
    sum_t round_inc;
    sum_t rounded;
    sum_t shifted;

    always_comb begin
        round_inc = '0;
        rounded   = i_sum;
        shifted   = i_sum;
        // zero shift passes straight through
        if (i_final_shift != 3'd0) begin
            round_inc = sum_t'(19'sd1 <<< (i_final_shift - 3'd1));
            rounded   = i_sum + round_inc;
            shifted   = rounded >>> i_final_shift;
        end
    end

    // ----------------------------------------
    // saturate to 14 bits
    // ----------------------------------------
    // clamp to -8192 .. +8191
    always_comb begin
        if (shifted > 19'sd8191) begin
            o_system = 14'h1fff;
        end else if (shifted < -19'sd8192) begin
            o_system = 14'h2000;
        end else begin
            o_system = shifted[13:0];
        end
    end

endmodule

`default_nettype wire

/* hw/dac_formatter.sv */
`default_nettype none

module dac_formatter
    import mix_pkg::*;
(
    input  wire         sys_clk,
    input  wire         rst,
    input  ch_samples_t i_rx_samples,
    input  sample_t     i_source0,
    input  dac_word_t   i_system,
    input  dac1_sel_t   i_dac1_sel,
    input  dac2_sel_t   i_dac2_sel,
    output dac_word_t   o_dac1_code,
    output dac_word_t   o_dac2_code
);

    // offset binary midscale
    localparam dac_word_t MIDSCALE = 14'd8192;

    // ----------------------------------------
    // source select, signed 14-bit
    // ----------------------------------------
    dac_word_t dac1_in;
    dac_word_t dac2_in;

    always_comb begin
        case (i_dac1_sel)
            D1_CH0:    dac1_in = i_rx_samples[0][15:2];
            D1_CH4:    dac1_in = i_rx_samples[4][15:2];
            D1_SYSTEM: dac1_in = i_system;
            // was the nco, zero reads as midscale
            default:   dac1_in = '0;
        endcase
    end

    always_comb begin
        case (i_dac2_sel)
            D2_CH1:  dac2_in = i_rx_samples[1][15:2];
            D2_CH2:  dac2_in = i_rx_samples[2][15:2];
            D2_CH3:  dac2_in = i_rx_samples[3][15:2];
            default: dac2_in = i_source0[15:2];
        endcase
    end

    // ----------------------------------------
    // offset binary registers
    // ----------------------------------------
    // add midscale, wraps mod 2^14
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            o_dac1_code <= MIDSCALE;
            o_dac2_code <= MIDSCALE;
        end else begin
            o_dac1_code <= dac1_in + MIDSCALE;
            o_dac2_code <= dac2_in + MIDSCALE;
        end
    end

endmodule

`default_nettype wire

/* hw/uberclock_mix_top.sv */
`default_nettype none

module uberclock_mix_top
    import mix_pkg::*;
#(
    parameter int GAIN_FRAC = 30
) (
    input  wire         sys_clk,
    input  wire         rst,
    input  adc_word_t   i_adc_data,
    input  wire [11:0]  i_ramp_step,
    input  ch_samples_t i_rx_samples,
    input  ch_gains_t   i_gains,
    input  sample_t     i_cpu_sample,
    input  mix_cfg_t    i_cfg,
    output in_sample_t  o_cap_selected,
    output dac_word_t   o_dac1_code,
    output dac_word_t   o_dac2_code
);

    // channel sources into the tree
    ch_samples_t sources;
    // tree output
    sum_t        sum;
    // scaled system output, also the feedback
    dac_word_t   system_out;

    // ----------------------------------------
    // input selection
    // ----------------------------------------
    adc_input_select u_input_select (
        .sys_clk        (sys_clk),
        .rst            (rst),
        .i_adc_data     (i_adc_data),
        .i_ramp_step    (i_ramp_step),
        .i_feedback     (system_out),
        .i_input_sel    (i_cfg.input_sel),
        .o_cap_selected (o_cap_selected)
    );

    // ----------------------------------------
    // channel sources
    // ----------------------------------------
    // one gain stage per rx sample, shared cpu sample
    for (genvar ch = 0; ch < NCH; ch++) begin : g_source
        channel_source #(
            .GAIN_FRAC (GAIN_FRAC)
        ) u_source (
            .sys_clk      (sys_clk),
            .rst          (rst),
            .i_rx_sample  (i_rx_samples[ch]),
            .i_gain       (i_gains[ch]),
            .i_cpu_sample (i_cpu_sample),
            .i_src_sel    (i_cfg.src_sel),
            .o_source     (sources[ch])
        );
    end

    // ----------------------------------------
    // sum and scale
    // ----------------------------------------
    sum_tree u_sum_tree (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .i_sources (sources),
        .o_sum     (sum)
    );

    // combinational, feeds the dac and the feedback
    output_scaler u_scaler (
        .i_sum         (sum),
        .i_final_shift (i_cfg.final_shift),
        .o_system      (system_out)
    );

    // ----------------------------------------
    // dac outputs
    // ----------------------------------------
    dac_formatter u_dac_fmt (
        .sys_clk      (sys_clk),
        .rst          (rst),
        .i_rx_samples (i_rx_samples),
        .i_source0    (sources[0]),
        .i_system     (system_out),
        .i_dac1_sel   (i_cfg.dac1_sel),
        .i_dac2_sel   (i_cfg.dac2_sel),
        .o_dac1_code  (o_dac1_code),
        .o_dac2_code  (o_dac2_code)
    );

endmodule

`default_nettype wire

/* verification/mix_checker.sv */
`default_nettype none

module mix_checker
    import mix_pkg::*;
(
    input wire        sys_clk,
    input wire        rst,
    input dac_word_t  i_dac1_code,
    input dac_word_t  i_dac2_code,
    input in_sample_t i_cap_selected
);

    timeunit 1ns;
    timeprecision 100ps;

    // ----------------------------------------
    // reset values
    // ----------------------------------------
    // one edge after rst is seen, registers hold reset values
    a_reset_dac1: assert property (@(posedge sys_clk) rst |=> i_dac1_code == 14'd8192)
        else $error("dac1 code is not midscale in reset");
    a_reset_dac2: assert property (@(posedge sys_clk) rst |=> i_dac2_code == 14'd8192)
        else $error("dac2 code is not midscale in reset");
    a_reset_cap: assert property (@(posedge sys_clk) rst |=> i_cap_selected == '0)
        else $error("captured sample is not zero in reset");

    // no unknowns once running
    a_known: assert property (@(posedge sys_clk)
        !rst |-> !$isunknown({i_dac1_code, i_dac2_code, i_cap_selected}))
        else $error("unknown value on a dut output");

endmodule

bind uberclock_mix_top mix_checker u_mix_checker (
    .sys_clk        (sys_clk),
    .rst            (rst),
    .i_dac1_code    (o_dac1_code),
    .i_dac2_code    (o_dac2_code),
    .i_cap_selected (o_cap_selected)
);

`default_nettype wire

/* verification/tb_mix.sv */
`default_nettype none

module tb_mix
    import mix_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int GAIN_FRAC    = 30;
    localparam int RESET_CYCLES = 10;
    // reset, settle, gain sweep, saturation, bypass, input select, drain
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 + 8 * 40 + 2 * 12 + 16 * 6 + 4 * 30 + 10;
    localparam int CYCLE_LIMIT  = TEST_CYCLES + 100;
    localparam int HIST         = 1024;

    logic        sys_clk;
    logic        rst;
    adc_word_t   adc_data;
    logic [11:0] ramp_step;
    ch_samples_t rx_samples;
    ch_gains_t   gains;
    sample_t     cpu_sample;
    mix_cfg_t    cfg;
    in_sample_t  cap_selected;
    dac_word_t   dac1_code;
    dac_word_t   dac2_code;

    logic [31:0] rng_state = 32'h2347be25;
    int          error_count;
    int          cycle_cnt;
    int          edge_cnt;
    string       test_name;

    // input history indexed by clock edges since reset release
    ch_samples_t rx_h   [HIST];
    ch_gains_t   gain_h [HIST];
    sample_t     cpu_h  [HIST];
    mix_cfg_t    cfg_h  [HIST];
    adc_word_t   adc_h  [HIST];
    logic [15:0] ramp_h [HIST];

    uberclock_mix_top #(
        .GAIN_FRAC (GAIN_FRAC)
    ) i_dut (
        .sys_clk        (sys_clk),
        .rst            (rst),
        .i_adc_data     (adc_data),
        .i_ramp_step    (ramp_step),
        .i_rx_samples   (rx_samples),
        .i_gains        (gains),
        .i_cpu_sample   (cpu_sample),
        .i_cfg          (cfg),
        .o_cap_selected (cap_selected),
        .o_dac1_code    (dac1_code),
        .o_dac2_code    (dac2_code)
    );

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    // ----------------------------------------
    // random numbers and checking
    // ----------------------------------------
    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [31:0] rand32();
        rng_state = lcg_step(rng_state);
        return rng_state;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    // channel source after edge k (zero while in reset)
    function automatic sample_t source_at(input int k, input int ch);
        longint  prod;
        sample_t rx;
        if (k <= 0) return '0;
        rx = rx_h[k][ch];
        case (cfg_h[k].src_sel)
            SRC_GAIN: begin
                // non-negative gain with GAIN_FRAC fraction bits
                prod = longint'(rx) * longint'({1'b0, gain_h[k][ch]});
                return sample_t'(prod >>> GAIN_FRAC);
            end
            SRC_CPU: return cpu_h[k];
            default: return '0;
        endcase
    endfunction

    // tree output after edge t lags the sources by three edges
    function automatic int tree_sum_at(input int t);
        int s;
        s = 0;
        for (int ch = 0; ch < NCH; ch++) begin
            s += int'(source_at(t - 3, ch));
        end
        return s;
    endfunction

    // round half up then shift and clamp to 14 bits signed
    function automatic dac_word_t scaled_output_at(input int t, input shift_t shift);
        int v;
        int sh;
        v  = tree_sum_at(t);
        sh = int'(shift);
        if (sh != 0) v = (v + (1 << (sh - 1))) >>> sh;
        if (v > 8191) v = 8191;
        if (v < -8192) v = -8192;
        return dac_word_t'(v);
    endfunction

    // signed to offset binary
    function automatic dac_word_t to_offset(input dac_word_t w);
        return dac_word_t'(w + 14'd8192);
    endfunction

    function automatic dac_word_t dac1_code_at(input int e);
        case (cfg_h[e].dac1_sel)
            D1_CH0:    return to_offset(rx_h[e][0][15:2]);
            D1_CH4:    return to_offset(rx_h[e][4][15:2]);
            D1_SYSTEM: return to_offset(scaled_output_at(e - 1, cfg_h[e].final_shift));
            default:   return to_offset('0);
        endcase
    endfunction

    function automatic dac_word_t dac2_code_at(input int e);
        sample_t src0;
        src0 = source_at(e - 1, 0);
        case (cfg_h[e].dac2_sel)
            D2_CH1:  return to_offset(rx_h[e][1][15:2]);
            D2_CH2:  return to_offset(rx_h[e][2][15:2]);
            D2_CH3:  return to_offset(rx_h[e][3][15:2]);
            default: return to_offset(src0[15:2]);
        endcase
    endfunction

    function automatic in_sample_t capture_at(input int e);
        dac_word_t sys;
        adc_word_t adc;
        sys = scaled_output_at(e - 1, cfg_h[e].final_shift);
        adc = (e - 1 <= 0) ? 12'h800 : adc_h[e - 1];
        case (cfg_h[e].input_sel)
            // msb flip
            // the adc register reads zero out of reset
            IN_ADC:      return in_sample_t'({~adc[11], adc[10:0]});
            IN_RAMP:     return in_sample_t'(ramp_h[e - 1][15:4] - 12'd2048);
            IN_FEEDBACK: return in_sample_t'(sys[13:2]);
            default:     return '0;
        endcase
    endfunction

    // record what the dut samples at each edge
    always @(posedge sys_clk) begin
        cycle_cnt++;
        if (!rst) begin
            edge_cnt++;
            rx_h[edge_cnt]   = rx_samples;
            gain_h[edge_cnt] = gains;
            cpu_h[edge_cnt]  = cpu_sample;
            cfg_h[edge_cnt]  = cfg;
            adc_h[edge_cnt]  = adc_data;
            ramp_h[edge_cnt] = ramp_h[edge_cnt - 1] + {4'd0, ramp_step};
        end
    end

    // compare on the falling edge when outputs are settled
    always @(negedge sys_clk) begin
        if (rst) begin
            compare_value("reset/dac1", 14'd8192, dac1_code);
            compare_value("reset/dac2", 14'd8192, dac2_code);
            compare_value("reset/cap", '0, cap_selected);
        end else if (edge_cnt > 0) begin
            compare_value($sformatf("%s/dac1", test_name), dac1_code_at(edge_cnt), dac1_code);
            compare_value($sformatf("%s/dac2", test_name), dac2_code_at(edge_cnt), dac2_code);
            compare_value($sformatf("%s/cap", test_name), capture_at(edge_cnt), cap_selected);
        end
    end

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic next_cycle();
        @(posedge sys_clk);
        #1;
    endtask

    task automatic randomize_channels();
        for (int ch = 0; ch < NCH; ch++) begin
            rx_samples[ch] = sample_t'(rand32() >> 8);
            gains[ch]      = rand32();
        end
        cpu_sample = sample_t'(rand32() >> 8);
        adc_data   = adc_word_t'(rand32() >> 12);
    endtask

    initial begin
        // ramp accumulator is cleared by reset
        ramp_h[0]  = '0;
        rst        = 1'b1;
        adc_data   = '0;
        ramp_step  = 12'(rand32() >> 20);
        rx_samples = '0;
        gains      = '0;
        cpu_sample = '0;
        cfg        = '{input_sel: IN_NONE, src_sel: SRC_GAIN, dac1_sel: D1_SYSTEM,
                       dac2_sel: D2_SRC0, final_shift: 3'd0};
        test_name  = "reset";
        repeat (RESET_CYCLES) @(posedge sys_clk);
        #1;
        rst = 1'b0;
        // first edge out of reset with idle inputs
        @(posedge sys_clk);
        @(negedge sys_clk);
        compare_value("reset/first dac1", 14'd8192, dac1_code);
        compare_value("reset/first dac2", 14'd8192, dac2_code);
        compare_value("reset/first cap", '0, cap_selected);

        // gain and sum path over every final shift
        test_name = "gain_sum";
        for (int sh = 0; sh < 8; sh++) begin
            for (int n = 0; n < 40; n++) begin
                next_cycle();
                cfg.final_shift = shift_t'(sh);
                cfg.dac2_sel    = dac2_sel_t'(rand32() >> 30);
                randomize_channels();
            end
        end

        // unity gain with five large samples of one sign
        test_name = "saturate";
        for (int pol = 0; pol < 2; pol++) begin
            for (int n = 0; n < 12; n++) begin
                next_cycle();
                cfg.final_shift = '0;
                for (int ch = 0; ch < NCH; ch++) begin
                    gains[ch]      = 32'd1 << GAIN_FRAC;
                    rx_samples[ch] = (pol == 0) ? {2'b01, 14'(rand32() >> 18)}
                                                : {2'b10, 14'(rand32() >> 18)};
                end
            end
            @(negedge sys_clk);
            compare_value("saturate/level", (pol == 0) ? 14'd16383 : 14'd0, dac1_code);
        end

        // cpu bypass over every dac select pair
        test_name = "cpu_bypass";
        for (int d1 = 0; d1 < 4; d1++) begin
            for (int d2 = 0; d2 < 4; d2++) begin
                for (int n = 0; n < 6; n++) begin
                    next_cycle();
                    cfg.src_sel     = SRC_CPU;
                    cfg.dac1_sel    = dac1_sel_t'(d1);
                    cfg.dac2_sel    = dac2_sel_t'(d2);
                    cfg.final_shift = shift_t'(rand32() >> 29);
                    randomize_channels();
                end
            end
        end

        // captured input with gains below unity to keep the feedback in range
        test_name = "input_select";
        for (int s = 0; s < 4; s++) begin
            for (int n = 0; n < 30; n++) begin
                next_cycle();
                cfg.input_sel   = input_sel_t'(s);
                cfg.src_sel     = SRC_GAIN;
                cfg.dac1_sel    = D1_SYSTEM;
                cfg.final_shift = shift_t'(rand32() >> 29);
                randomize_channels();
                for (int ch = 0; ch < NCH; ch++) gains[ch] = rand32() >> 2;
            end
        end

        test_name = "drain";
        repeat (10) next_cycle();
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hw/mix_pkg.sv
hw/adc_input_select.sv
hw/channel_source.sv
hw/sum_tree.sv
hw/output_scaler.sv
hw/dac_formatter.sv
hw/uberclock_mix_top.sv
verification/mix_checker.sv
verification/tb_mix.sv

/* Makefile */
# Verilator build and run of the mixer testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := tb_mix
FILELIST := project.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# pass or fail is decided by the log
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
